//--- design/btn_debounce_fsm.sv
`timescale 1ns/1ps

// Push button debouncer, one intr pulse per accepted press
module btn_debounce_fsm
    import rat_io_pkg::*;
#(
    parameter int DB_SAMPLES = 4
) (
    input  logic CLK,
    input  logic arst_n,
    input  logic btn,
    input  logic sample_tick,
    output logic intr
);

    // Counts up to DB_SAMPLES disagreeing samples
    localparam int CNT_W = $clog2(DB_SAMPLES + 1);
    localparam logic [CNT_W-1:0] DONE = CNT_W'(DB_SAMPLES);

    logic             btn_meta;
    logic             btn_sync;
    db_state_t        state_q;
    db_state_t        state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic [CNT_W-1:0] cnt_inc;
    logic             press_d;

    ////////////////////
    // Synchronizer
    ////////////////////

    // Two flops, the button is asynchronous to CLK
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    ////////////////////
    // Next state
    ////////////////////

    assign cnt_inc = cnt_q + 1'b1;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        press_d = 1'b0;
        // Only act on sample ticks
        if (sample_tick) begin
            case (state_q)
                // Accepted level is released
                IDLE, PRESS_WAIT: begin
                    if (btn_sync) begin
                        if (cnt_inc == DONE) begin
                            state_d = HELD;
                            cnt_d   = '0;
                            press_d = 1'b1;
                        end else begin
                            state_d = PRESS_WAIT;
                            cnt_d   = cnt_inc;
                        end
                    end else begin
                        // Agreeing sample, glitch discarded
                        state_d = IDLE;
                        cnt_d   = '0;
                    end
                end
                // Accepted level is pressed
                HELD, RELEASE_WAIT: begin
                    if (!btn_sync) begin
                        if (cnt_inc == DONE) begin
                            state_d = IDLE;
                            cnt_d   = '0;
                        end else begin
                            state_d = RELEASE_WAIT;
                            cnt_d   = cnt_inc;
                        end
                    end else begin
                        state_d = HELD;
                        cnt_d   = '0;
                    end
                end
                default: begin
                    state_d = IDLE;
                    cnt_d   = '0;
                end
            endcase
        end
    end

    ////////////////////
    // State and pulse registers
    ////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            intr    <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            // High for the single cycle after PRESS_WAIT to HELD
            intr    <= press_d;
        end
    end

endmodule

//--- design/io_port_regs.sv
`timescale 1ns/1ps

// Port-mapped input mux and output registers
module io_port_regs
    import rat_io_pkg::*;
(
    input  logic       CLK,
    input  logic       arst_n,
    port_bus_if.periph bus,
    input  port_data_t switches,
    output port_data_t leds,
    output port_data_t seg_value
);

    ////////////////////
    // Input ports
    ////////////////////

    // Read needs no strobe, follows port_id directly
    always_comb begin
        if (bus.port_id == SWITCHES_ID) begin
            bus.in_port = switches;
        end else begin
            // Unmapped read address returns zero
            bus.in_port = '0;
        end
    end

    ////////////////////
    // Output ports
    ////////////////////

    // LED register
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (bus.io_strb && (bus.port_id == LEDS_ID)) begin
            leds <= bus.out_port;
        end
    end

    // Display value register
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            seg_value <= '0;
        end else if (bus.io_strb && (bus.port_id == SEG_ID)) begin
            seg_value <= bus.out_port;
        end
    end

    // Any other strobed address falls through both registers

endmodule

//--- design/port_bus_if.sv
`timescale 1ns/1ps

// Processor port bus, no handshake
interface port_bus_if import rat_io_pkg::*; ();

    // Address of the port being read or written
    port_id_t   port_id;
    // Write data from the processor
    port_data_t out_port;
    // Write strobe, one write per high cycle
    logic       io_strb;
    // Read data back to the processor
    port_data_t in_port;

    // Processor side
    modport master (
        output port_id, out_port, io_strb,
        input  in_port
    );

    // Peripheral side
    modport periph (
        input  port_id, out_port, io_strb,
        output in_port
    );

endinterface

//--- design/rat_io_pkg.sv
package rat_io_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int PORT_W  = 8;
    localparam int DATA_W  = 8;
    localparam int DIGIT_W = 4;

    // Port address on the processor bus
    typedef logic [PORT_W-1:0] port_id_t;

    // Data byte for switches, LEDs, display value and both port directions
    typedef logic [DATA_W-1:0] port_data_t;

    // One BCD decimal digit
    typedef logic [DIGIT_W-1:0] digit_t;

    ////////////////////
    // Port address map
    ////////////////////

    // Input ports
    localparam port_id_t SWITCHES_ID = 8'hFF;

    // Output ports
    localparam port_id_t LEDS_ID     = 8'h40;
    localparam port_id_t SEG_ID      = 8'h81;

    ////////////////////
    // Debounce FSM states
    ////////////////////

    // Released, pressed candidate, accepted press, release candidate
    typedef enum logic [1:0] {
        IDLE,
        PRESS_WAIT,
        HELD,
        RELEASE_WAIT
    } db_state_t;

endpackage

//--- design/rat_io_sys.sv
`timescale 1ns/1ps

// I/O subsystem around the processor port bus
module rat_io_sys
    import rat_io_pkg::*;
#(
    parameter int SCAN_PERIOD = 50000,
    parameter int DB_PERIOD   = 10000,
    parameter int DB_SAMPLES  = 4
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  port_id_t   port_id,
    input  port_data_t out_port,
    input  logic       io_strb,
    output port_data_t in_port,
    input  port_data_t switches,
    input  logic       btn,
    output logic       intr,
    output port_data_t leds,
    output logic [3:0] anodes,
    output logic [7:0] cathodes
);

    logic       scan_tick;
    logic       sample_tick;
    port_data_t seg_value;

    ////////////////////
    // Port bus
    ////////////////////

    port_bus_if bus ();

    // Top ports play the master role on the bus
    assign bus.port_id  = port_id;
    assign bus.out_port = out_port;
    assign bus.io_strb  = io_strb;
    assign in_port      = bus.in_port;

    // Switch mux plus LED and display registers
    io_port_regs u_io_port_regs (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .bus       (bus.periph),
        .switches  (switches),
        .leds      (leds),
        .seg_value (seg_value)
    );

    ////////////////////
    // Display
    ////////////////////

    // One digit per scan period
    tick_timer #(.PERIOD(SCAN_PERIOD)) u_scan_timer (
        .CLK    (CLK),
        .arst_n (arst_n),
        .tick   (scan_tick)
    );

    sseg_decimal u_sseg_decimal (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .scan_tick (scan_tick),
        .seg_value (seg_value),
        .anodes    (anodes),
        .cathodes  (cathodes)
    );

    ////////////////////
    // Interrupt button
    ////////////////////

    // Button sample rate
    tick_timer #(.PERIOD(DB_PERIOD)) u_sample_timer (
        .CLK    (CLK),
        .arst_n (arst_n),
        .tick   (sample_tick)
    );

    btn_debounce_fsm #(.DB_SAMPLES(DB_SAMPLES)) u_btn_debounce_fsm (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .btn         (btn),
        .sample_tick (sample_tick),
        .intr        (intr)
    );

endmodule

//--- design/sseg_decimal.sv
`timescale 1ns/1ps

// Three-digit decimal seven-segment driver, multiplexed
module sseg_decimal
    import rat_io_pkg::*;
(
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       scan_tick,
    input  port_data_t seg_value,
    output logic [3:0] anodes,
    output logic [7:0] cathodes
);

    // Highest scan index, digit 3 stays dark
    localparam logic [1:0] LAST_IDX = 2'd2;

    logic [11:0] bcd;
    digit_t      ones;
    digit_t      tens;
    digit_t      hundreds;
    digit_t      digit_sel;
    logic [1:0]  scan_idx;
    logic [1:0]  scan_idx_next;

    ////////////////////
    // Segment encoder
    ////////////////////

    // Active low, bit 0 is segment a through bit 6 segment g
    function automatic logic [6:0] seg_encode(input digit_t d);
        logic [6:0] seg;
        case (d)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            // Not a BCD digit, blank
            default: seg = 7'b1111111;
        endcase
        return seg;
    endfunction

    ////////////////////
    // Binary to BCD
    ////////////////////

    // Shift-and-add-3 over the 8 input bits
    always_comb begin
        bcd = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            // Correct any digit of 5 or more before the shift
            if (bcd[3:0] >= 4'd5) begin
                bcd[3:0] = bcd[3:0] + 4'd3;
            end
            if (bcd[7:4] >= 4'd5) begin
                bcd[7:4] = bcd[7:4] + 4'd3;
            end
            if (bcd[11:8] >= 4'd5) begin
                bcd[11:8] = bcd[11:8] + 4'd3;
            end
            bcd = {bcd[10:0], seg_value[i]};
        end
    end

    assign ones     = bcd[3:0];
    assign tens     = bcd[7:4];
    // At most 2 for an 8-bit value
    assign hundreds = bcd[11:8];

    ////////////////////
    // Digit select
    ////////////////////

    // Index 0 is the ones digit on anode 0
    always_comb begin
        case (scan_idx)
            2'd0:    digit_sel = ones;
            2'd1:    digit_sel = tens;
            default: digit_sel = hundreds;
        endcase
    end

    // Wrap after the hundreds digit
    assign scan_idx_next = (scan_idx == LAST_IDX) ? 2'd0 : scan_idx + 2'd1;

    ////////////////////
    // Scan registers
    ////////////////////

    // Anode and pattern load together, display dark until the first tick
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            scan_idx <= 2'd0;
            anodes   <= 4'hF;
            cathodes <= 8'hFF;
        end else if (scan_tick) begin
            // One-cold, scan_idx never reaches 3
            anodes   <= ~(4'b0001 << scan_idx);
            // Decimal point held off
            cathodes <= {1'b1, seg_encode(digit_sel)};
            scan_idx <= scan_idx_next;
        end
    end

endmodule

//--- design/tick_timer.sv
`timescale 1ns/1ps

// Free-running tick generator, one pulse every PERIOD clocks
module tick_timer #(
    parameter int PERIOD = 50000
) (
    input  logic CLK,
    input  logic arst_n,
    output logic tick
);

    // Counter only has to hold PERIOD-1
    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(PERIOD - 1);

    logic [CNT_W-1:0] cnt;

    ////////////////////
    // Down-counter
    ////////////////////

    // Starts at PERIOD-1 so the first zero lands PERIOD clocks after reset
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= RELOAD;
        end else if (cnt == '0) begin
            cnt <= RELOAD;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // Tick on the zero cycle, consumers sample it on the next edge
    assign tick = (cnt == '0);

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

// Testbench clock and reset source
module tb_clk_gen #(
    parameter real HALF_PERIOD  = 20.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic CLK,
    output logic arst_n
);

    // 40 ns period by default
    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // Reset falls just after time zero, ahead of the first rising edge
    initial begin
        arst_n = 1'b1;
        #5 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        // Release on a falling edge
        @(negedge CLK);
        arst_n = 1'b1;
    end

endmodule

//--- verification/tb_rat_io_sys.sv
`timescale 1ns/1ps

// Testbench for the port-mapped I/O subsystem, acts as bus master
module tb_rat_io_sys import rat_io_pkg::*; ();

    localparam int SCAN_PERIOD  = 8;
    localparam int DB_PERIOD    = 4;
    localparam int DB_SAMPLES   = 3;
    localparam int RESET_CYCLES = 8;
    localparam int BUS_CYCLES   = 300;
    localparam int DISP_VALUES  = 20;
    localparam int REL_GAP      = 30;
    // Worst press to intr latency
    localparam int PULSE_LIMIT  = (DB_SAMPLES + 1) * DB_PERIOD + 3;
    // Reset, bus cycles, 60 scan periods, 8 trials of 40 samples, plus 25 %
    localparam int TIMEOUT = (RESET_CYCLES + BUS_CYCLES + 60 * SCAN_PERIOD
                              + 8 * 40 * DB_PERIOD) * 5 / 4;

    logic       CLK;
    logic       arst_n;
    port_id_t   port_id;
    port_data_t out_port;
    logic       io_strb;
    port_data_t in_port;
    port_data_t switches;
    logic       btn;
    logic       intr;
    port_data_t leds;
    logic [3:0] anodes;
    logic [7:0] cathodes;

    // Reference model state
    port_data_t  leds_model;
    port_data_t  seg_model;
    logic [3:0]  exp_anodes;
    logic [7:0]  exp_cathodes;
    int          scan_gap;
    int          scan_idx;
    int          seen_pulses;
    int          exp_pulses;
    int          press_age;
    int          cycles = 0;
    logic [31:0] lfsr;

    tb_clk_gen #(.HALF_PERIOD(20.0), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .CLK    (CLK),
        .arst_n (arst_n)
    );

    rat_io_sys #(
        .SCAN_PERIOD (SCAN_PERIOD),
        .DB_PERIOD   (DB_PERIOD),
        .DB_SAMPLES  (DB_SAMPLES)
    ) dut (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .port_id  (port_id),
        .out_port (out_port),
        .io_strb  (io_strb),
        .in_port  (in_port),
        .switches (switches),
        .btn      (btn),
        .intr     (intr),
        .leds     (leds),
        .anodes   (anodes),
        .cathodes (cathodes)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Three of four picks hit a mapped port
    function automatic port_id_t pick_port();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    return SWITCHES_ID;
            2'd1:    return LEDS_ID;
            2'd2:    return SEG_ID;
            default: return port_id_t'(rand_bits(8));
        endcase
    endfunction

    // Decimal digit by position, 0 is ones
    function automatic digit_t decimal_digit(input port_data_t v, input int idx);
        case (idx)
            0:       return digit_t'(v % 10);
            1:       return digit_t'((v / 10) % 10);
            default: return digit_t'(v / 100);
        endcase
    endfunction

    // Lit segments, active high, gfedcba
    function automatic logic [6:0] lit_segments(input digit_t d);
        case (d)
            4'd0: return 7'h3F;
            4'd1: return 7'h06;
            4'd2: return 7'h5B;
            4'd3: return 7'h4F;
            4'd4: return 7'h66;
            4'd5: return 7'h6D;
            4'd6: return 7'h7D;
            4'd7: return 7'h07;
            4'd8: return 7'h7F;
            default: return 7'h6F;
        endcase
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        $display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, exp_v, act_v);
        $display("CHECKS FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic rule_error(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    // Button level held for a number of cycles
    task automatic hold_btn(input logic level, input int n);
        @(negedge CLK);
        btn = level;
        repeat (n - 1) @(negedge CLK);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            leds_model   <= '0;
            seg_model    <= '0;
            exp_anodes   <= 4'hF;
            exp_cathodes <= 8'hFF;
            scan_gap     <= 0;
            scan_idx     <= 0;
            seen_pulses  <= 0;
            press_age    <= 0;
        end else begin
            if (io_strb && port_id == LEDS_ID) begin
                leds_model <= out_port;
            end
            if (io_strb && port_id == SEG_ID) begin
                seg_model <= out_port;
            end
            // New digit every SCAN_PERIOD cycles, ones then tens then hundreds
            if (scan_gap == SCAN_PERIOD - 1) begin
                scan_gap     <= 0;
                exp_anodes   <= (scan_idx == 0) ? 4'b1110 : (scan_idx == 1) ? 4'b1101 : 4'b1011;
                exp_cathodes <= {1'b1, ~lit_segments(decimal_digit(seg_model, scan_idx))};
                scan_idx     <= (scan_idx + 1) % 3;
            end else begin
                scan_gap <= scan_gap + 1;
            end
            if (intr) begin
                seen_pulses <= seen_pulses + 1;
            end
            // Cycles since the button last went high
            press_age <= btn ? press_age + 1 : 0;
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    a_in_port: assert property (@(posedge CLK)
        in_port == ((port_id == SWITCHES_ID) ? switches : 8'h00))
        else value_error("in_port", ($sampled(port_id) == SWITCHES_ID) ? $sampled(switches) : 0,
                         $sampled(in_port));
    a_leds: assert property (@(posedge CLK) leds == leds_model)
        else value_error("leds", $sampled(leds_model), $sampled(leds));
    a_anodes: assert property (@(posedge CLK) anodes == exp_anodes)
        else value_error("anodes", $sampled(exp_anodes), $sampled(anodes));
    a_cathodes: assert property (@(posedge CLK) cathodes == exp_cathodes)
        else value_error("cathodes", $sampled(exp_cathodes), $sampled(cathodes));
    a_one_cold: assert property (@(posedge CLK) disable iff (!arst_n)
        (anodes != $past(anodes)) |-> (anodes[3] && $onehot(~anodes[2:0])))
        else rule_error("anodes changed to a pattern that is not one digit low");
    a_intr_width: assert property (@(posedge CLK) disable iff (!arst_n) intr |=> !intr)
        else rule_error("intr stayed high for more than one cycle");
    a_no_extra: assert property (@(posedge CLK) seen_pulses <= exp_pulses)
        else rule_error("intr pulsed without an accepted press");
    a_deadline: assert property (@(posedge CLK)
        (press_age > PULSE_LIMIT) |-> (seen_pulses == exp_pulses))
        else rule_error("no intr pulse within the debounce latency of a press");
    a_reset: assert property (@(posedge CLK)
        !arst_n |-> (leds == 8'h00 && anodes == 4'hF && cathodes == 8'hFF && !intr))
        else rule_error("outputs not at their reset values while reset is low");

    // Run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        lfsr       = 32'h1437;
        port_id    = '0;
        out_port   = '0;
        io_strb    = 1'b0;
        switches   = '0;
        btn        = 1'b0;
        exp_pulses = 0;
        @(posedge arst_n);
        // Random bus traffic, reads and writes mixed
        repeat (BUS_CYCLES) begin
            @(negedge CLK);
            port_id  = pick_port();
            out_port = port_data_t'(rand_bits(8));
            switches = port_data_t'(rand_bits(8));
            io_strb  = (rand_bits(2) != 0);
        end
        // Display values held for a full scan of three digits
        for (int n = 0; n < DISP_VALUES; n++) begin
            @(negedge CLK);
            port_id  = SEG_ID;
            out_port = (n == 0) ? 8'd255 : (n == 1) ? 8'd100 : port_data_t'(rand_bits(8));
            io_strb  = 1'b1;
            @(negedge CLK);
            io_strb = 1'b0;
            repeat (3 * SCAN_PERIOD - 2) @(negedge CLK);
        end
        // Clean press
        exp_pulses++;
        hold_btn(1'b1, 40);
        hold_btn(1'b0, REL_GAP);
        // Single glitch
        hold_btn(1'b1, 1 + int'(rand_bits(3)) % 7);
        hold_btn(1'b0, REL_GAP);
        // Long hold, still one pulse
        exp_pulses++;
        hold_btn(1'b1, 100);
        hold_btn(1'b0, REL_GAP);
        // Short release then re-press
        exp_pulses++;
        hold_btn(1'b1, 30);
        hold_btn(1'b0, 1 + int'(rand_bits(3)) % 7);
        hold_btn(1'b1, 40);
        hold_btn(1'b0, REL_GAP);
        // Two glitches apart
        hold_btn(1'b1, 1 + int'(rand_bits(3)) % 7);
        hold_btn(1'b0, 8);
        hold_btn(1'b1, 1 + int'(rand_bits(3)) % 7);
        hold_btn(1'b0, REL_GAP);
        // Contact bounce before a steady press
        exp_pulses++;
        hold_btn(1'b1, 2);
        hold_btn(1'b0, 1);
        hold_btn(1'b1, 3);
        hold_btn(1'b0, 2);
        hold_btn(1'b1, 40);
        hold_btn(1'b0, REL_GAP);
        // Random clean holds
        repeat (2) begin
            exp_pulses++;
            hold_btn(1'b1, 21 + int'(rand_bits(5)));
            hold_btn(1'b0, REL_GAP);
        end
        repeat (4) @(negedge CLK);
        if (seen_pulses != exp_pulses) begin
            $display("Saw %0d intr pulses for %0d accepted presses", seen_pulses, exp_pulses);
            $display("CHECKS FAILED");
            $fatal(1, "interrupt count");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
design/rat_io_pkg.sv
design/port_bus_if.sv
design/tick_timer.sv
design/btn_debounce_fsm.sv
design/io_port_regs.sv
design/sseg_decimal.sv
design/rat_io_sys.sv
verification/tb_clk_gen.sv
verification/tb_rat_io_sys.sv
